// ==== byte_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module byte_fifo #(
  parameter int FIFO_DEPTH = 16
) (
  input  logic                               PHY_CLKOUT,
  input  logic                               RESET_IN,
  input  logic                               push_i,
  input  uart_line_pkg::byte_t               push_data_i,
  input  logic                               pop_i,
  output uart_line_pkg::byte_t               pop_data_o,
  output logic                               full_o,
  output logic [$clog2(FIFO_DEPTH + 1)-1:0]  count_o
);

  localparam int AW = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam logic [AW-1:0] LAST_SLOT = AW'(FIFO_DEPTH - 1);

  uart_line_pkg::byte_t mem [FIFO_DEPTH];
  logic [AW-1:0]        wr_ptr;
  logic [AW-1:0]        rd_ptr;
  logic                 push_ok;
  logic                 pop_ok;

  assign full_o     = (count_o == FIFO_DEPTH);
  assign push_ok    = push_i & ~full_o;
  assign pop_ok     = pop_i & (count_o != '0);
  assign pop_data_o = mem[rd_ptr];                 // fall-through head

  always_ff @(posedge PHY_CLKOUT) begin
    if (push_ok) begin
      mem[wr_ptr] <= push_data_i;
    end
  end

  always_ff @(posedge PHY_CLKOUT) begin
    if (RESET_IN) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      count_o <= '0;
    end else begin
      if (push_ok) begin
        wr_ptr <= (wr_ptr == LAST_SLOT) ? '0 : wr_ptr + 1'b1;
      end
      if (pop_ok) begin
        rd_ptr <= (rd_ptr == LAST_SLOT) ? '0 : rd_ptr + 1'b1;
      end
      case ({push_ok, pop_ok})
        2'b10:   count_o <= count_o + 1'b1;
        2'b01:   count_o <= count_o - 1'b1;
        default: count_o <= count_o;               // none or both
      endcase
    end
  end

  a_no_overflow: assert property (@(posedge PHY_CLKOUT) disable iff (RESET_IN)
    !(push_i && full_o));

  // upstream pop must follow a nonzero count
  a_no_underflow: assert property (@(posedge PHY_CLKOUT) disable iff (RESET_IN)
    !(pop_i && count_o == '0));

endmodule

`default_nettype wire

// ==== ep_port_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// link between the upstream arbiter and one uart channel
interface ep_port_if #(
  parameter int FIFO_DEPTH = 16
);

  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  // downstream, host to uart line
  logic                 rx_valid;
  uart_line_pkg::byte_t rx_data;
  logic                 rx_ready;                  // tx fifo has room

  // upstream, uart line to host
  logic [CNT_W-1:0]     tx_count;                  // rx fifo occupancy
  logic                 tx_pop;
  uart_line_pkg::byte_t tx_data;                   // rx fifo head

  modport arb (
    output rx_valid, rx_data, tx_pop,
    input  rx_ready, tx_count, tx_data
  );

  modport chan (
    input  rx_valid, rx_data, tx_pop,
    output rx_ready, tx_count, tx_data
  );

endinterface

`default_nettype wire

// ==== filelist.f ====
uart_line_pkg.sv
usb_ep_pkg.sv
ep_port_if.sv
byte_fifo.sv
uart_channel.sv
gpio_endpoint.sv
usb_ep_arbiter.sv
usb_bridge_top.sv
usb_bridge_checker.sv
tb_usb_bridge.sv

// ==== gpio_endpoint.sv ====
`timescale 1ns/1ps
`default_nettype none

module gpio_endpoint (
  input  logic                 PHY_CLKOUT,
  input  logic                 RESET_IN,
  input  logic                 byte_valid_i,
  input  uart_line_pkg::byte_t byte_data_i,
  input  logic                 byte_last_i,
  output logic [9:0]           parallel_o
);

  uart_line_pkg::byte_t prev_byte;                 // byte before the last one

  always_ff @(posedge PHY_CLKOUT) begin
    if (RESET_IN) begin
      prev_byte  <= '0;
      parallel_o <= '0;
    end else if (byte_valid_i) begin
      if (byte_last_i) begin
        parallel_o <= {byte_data_i[1:0], prev_byte};
        prev_byte  <= '0;                          // next packet starts clean
      end else begin
        prev_byte <= byte_data_i;
      end
    end
  end

endmodule

`default_nettype wire

// ==== tb_usb_bridge.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_usb_bridge;

  localparam int CLKS_PER_BIT  = 8;
  localparam int MAX_PKT_BYTES = 8;
  localparam int BEAT_LIMIT    = 2000;             // cycles for one downstream byte
  localparam int DRAIN_LIMIT   = 20000;
  localparam int QUIET_CYCLES  = 20 * CLKS_PER_BIT; // two frame times

  logic                 PHY_CLKOUT;
  logic                 RESET_IN;
  logic                 usb_rx_valid_i;
  uart_line_pkg::byte_t usb_rx_data_i;
  usb_ep_pkg::endpt_t   usb_rx_endpt_i;
  logic                 usb_rx_last_i;
  logic                 usb_rx_ready_o;
  logic                 usb_tx_valid_o;
  uart_line_pkg::byte_t usb_tx_data_o;
  usb_ep_pkg::endpt_t   usb_tx_endpt_o;
  logic                 usb_tx_last_o;
  logic                 usb_tx_pop_i;
  logic [2:0]           uart_line;                 // txd looped to rxd
  logic [9:0]           usb_parallel_o;

  integer               seed;
  logic [31:0]          rnd;
  logic                 pop_hold;
  integer               fd;
  integer               code;
  logic [63:0]          tag;
  logic [8*32-1:0]      test_name;
  logic [8*128-1:0]     skip_line;
  logic [31:0]          f_ep;
  logic [31:0]          f_cnt;
  logic [31:0]          f_data;
  logic [31:0]          exp_par;
  logic                 check_par;
  logic                 want_stall;
  int                   gap;

  usb_ep_pkg::endpt_t   beat_ep [$];
  uart_line_pkg::byte_t beat_data [$];
  logic                 beat_last [$];

  always #4 PHY_CLKOUT = ~PHY_CLKOUT;

  usb_bridge_top #(
    .CLKS_PER_BIT  (CLKS_PER_BIT),
    .MAX_PKT_BYTES (MAX_PKT_BYTES)
  ) usb_bridge_top_inst (
    .PHY_CLKOUT     (PHY_CLKOUT),
    .RESET_IN       (RESET_IN),
    .usb_rx_valid_i (usb_rx_valid_i),
    .usb_rx_data_i  (usb_rx_data_i),
    .usb_rx_endpt_i (usb_rx_endpt_i),
    .usb_rx_last_i  (usb_rx_last_i),
    .usb_rx_ready_o (usb_rx_ready_o),
    .usb_tx_valid_o (usb_tx_valid_o),
    .usb_tx_data_o  (usb_tx_data_o),
    .usb_tx_endpt_o (usb_tx_endpt_o),
    .usb_tx_last_o  (usb_tx_last_o),
    .usb_tx_pop_i   (usb_tx_pop_i),
    .usb_uart_txd_o (uart_line),
    .usb_uart_rxd_i (uart_line),
    .usb_parallel_o (usb_parallel_o)
  );

  usb_bridge_checker #(.MAX_PKT_BYTES(MAX_PKT_BYTES)) bridge_checker_inst (
    .PHY_CLKOUT (PHY_CLKOUT),
    .RESET_IN   (RESET_IN),
    .rx_valid_i (usb_rx_valid_i),
    .rx_ready_i (usb_rx_ready_o),
    .tx_valid_i (usb_tx_valid_o),
    .tx_data_i  (usb_tx_data_o),
    .tx_endpt_i (usb_tx_endpt_o),
    .tx_last_i  (usb_tx_last_o),
    .tx_pop_i   (usb_tx_pop_i),
    .parallel_i (usb_parallel_o),
    .uart_txd_i (uart_line)
  );

  // random host pops, held off during a back-pressure gap
  always @(posedge PHY_CLKOUT) begin
    rnd = $random(seed);
    if (RESET_IN || pop_hold) usb_tx_pop_i <= 1'b0;
    else usb_tx_pop_i <= rnd[0];
  end

  // ==========================================================
  // helpers
  // ==========================================================
  task automatic abort_run(input string what);
    $display("Error: %s at %0t ns", what, $time);
    bridge_checker_inst.report_summary();
    $display("TEST FAILED");
    $finish;
  endtask

  task automatic send_beat(input usb_ep_pkg::endpt_t ep, input uart_line_pkg::byte_t data,
                           input logic last);
    int waited;
    waited = 0;
    usb_rx_valid_i <= 1'b1;
    usb_rx_endpt_i <= ep;
    usb_rx_data_i  <= data;
    usb_rx_last_i  <= last;
    @(posedge PHY_CLKOUT);
    while (!usb_rx_ready_o) begin                  // taken on the first edge with ready
      waited++;
      if (waited > BEAT_LIMIT) abort_run("usb_rx_ready_o stayed low, byte never taken");
      @(posedge PHY_CLKOUT);
    end
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    while (bridge_checker_inst.pending() != 0) begin
      waited++;
      if (waited > DRAIN_LIMIT) abort_run("expected upstream bytes never arrived");
      @(posedge PHY_CLKOUT);
    end
    repeat (QUIET_CYCLES) @(posedge PHY_CLKOUT);   // a stray byte would show up here
  endtask

  task automatic run_test();
    bridge_checker_inst.begin_test();
    pop_hold <= (gap > 0);
    while (beat_ep.size() != 0) begin
      send_beat(beat_ep.pop_front(), beat_data.pop_front(), beat_last.pop_front());
    end
    usb_rx_valid_i <= 1'b0;
    usb_rx_last_i  <= 1'b0;
    if (gap > 0) begin
      repeat (gap) @(posedge PHY_CLKOUT);
      bridge_checker_inst.check_waiting();
      pop_hold <= 1'b0;
    end
    wait_drain();
    if (check_par) bridge_checker_inst.check_parallel(exp_par[9:0]);
    if (want_stall) bridge_checker_inst.check_stall();
    bridge_checker_inst.end_test(test_name);
  endtask

  // ==========================================================
  // sequencing
  // ==========================================================
  initial begin
    seed           = 32'h7bcf_178b;
    PHY_CLKOUT     = 1'b0;
    RESET_IN       = 1'b1;
    usb_rx_valid_i = 1'b0;
    usb_rx_data_i  = '0;
    usb_rx_endpt_i = '0;
    usb_rx_last_i  = 1'b0;
    usb_tx_pop_i   = 1'b0;
    pop_hold       = 1'b0;
    gap            = 0;
    check_par      = 1'b0;
    want_stall     = 1'b0;
    repeat (5) @(posedge PHY_CLKOUT);
    RESET_IN <= 1'b0;
    @(posedge PHY_CLKOUT);
    bridge_checker_inst.check_reset();

    fd = $fopen("usb_bridge_vectors.txt", "r");
    if (fd == 0) abort_run("cannot open usb_bridge_vectors.txt");
    while ($fscanf(fd, "%s", tag) == 1) begin
      case (tag)
        "#": code = $fgets(skip_line, fd);
        "T": begin
          code       = $fscanf(fd, "%s", test_name);
          gap        = 0;
          check_par  = 1'b0;
          want_stall = 1'b0;
        end
        "D": begin
          code = $fscanf(fd, "%h %h", f_ep, f_cnt);
          for (int i = 0; i < f_cnt; i++) begin
            code = $fscanf(fd, "%h", f_data);
            beat_ep.push_back(f_ep[3:0]);
            beat_data.push_back(f_data[7:0]);
            beat_last.push_back(i == f_cnt - 1);   // last on the final byte of the line
          end
        end
        "U": begin
          code = $fscanf(fd, "%h %h", f_ep, f_cnt);
          for (int i = 0; i < f_cnt; i++) begin
            code = $fscanf(fd, "%h", f_data);
            bridge_checker_inst.expect_byte(f_ep[3:0], f_data[7:0]);
          end
        end
        "P": begin
          code      = $fscanf(fd, "%h", exp_par);
          check_par = 1'b1;
        end
        "H": code = $fscanf(fd, "%d", gap);
        "R": want_stall = 1'b1;
        "E": run_test();
        default: abort_run("unknown record in usb_bridge_vectors.txt");
      endcase
    end
    $fclose(fd);

    bridge_checker_inst.report_summary();
    if (bridge_checker_inst.total_errors == 0 && bridge_checker_inst.tests_run > 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== uart_channel.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_channel #(
  parameter int CLKS_PER_BIT = 520,
  parameter int FIFO_DEPTH   = 16
) (
  input  logic         PHY_CLKOUT,
  input  logic         RESET_IN,
  ep_port_if.chan      port,
  output logic         uart_txd_o,
  input  logic         uart_rxd_i
);

  localparam int DB = uart_line_pkg::DATA_BITS;
  localparam int FB = uart_line_pkg::FRAME_BITS;
  localparam int CW = $clog2(CLKS_PER_BIT);
  localparam int QW = $clog2(FIFO_DEPTH + 1);

  localparam logic [CW-1:0] BIT_LAST  = CW'(CLKS_PER_BIT - 1);
  localparam logic [CW-1:0] HALF_LAST = CW'(CLKS_PER_BIT / 2 - 1);
  localparam logic [3:0]    STOP_IDX  = 4'(FB - 1);

  // downstream fifo, feeds the serializer
  logic                 down_full;
  logic                 down_pop;
  uart_line_pkg::byte_t down_data;
  logic [QW-1:0]        down_count;

  // upstream fifo, filled by the deserializer
  logic                 up_full;
  logic                 up_push;

  logic                 tx_busy;
  logic [FB-1:0]        tx_shift;
  logic [CW-1:0]        tx_clk_cnt;
  logic [3:0]           tx_bits_left;

  logic                 rxd_meta;
  logic                 rxd_sync;
  logic                 rx_active;
  logic                 rx_done;                   // stop bit was good
  logic [CW-1:0]        rx_clk_cnt;
  logic [3:0]           rx_bit_idx;                // 0 start, 1..8 data, 9 stop
  uart_line_pkg::byte_t rx_shift;

  assign port.rx_ready = ~down_full;

  byte_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) down_fifo_inst (
    .PHY_CLKOUT  (PHY_CLKOUT),
    .RESET_IN    (RESET_IN),
    .push_i      (port.rx_valid & ~down_full),
    .push_data_i (port.rx_data),
    .pop_i       (down_pop),
    .pop_data_o  (down_data),
    .full_o      (down_full),
    .count_o     (down_count)
  );

  // ==========================================================
  // serializer
  // ==========================================================
  assign down_pop   = ~tx_busy & (down_count != '0);
  assign uart_txd_o = tx_shift[0];

  always_ff @(posedge PHY_CLKOUT) begin
    if (RESET_IN) begin
      tx_busy      <= 1'b0;
      tx_shift     <= '1;                          // line idles high
      tx_clk_cnt   <= '0;
      tx_bits_left <= '0;
    end else if (down_pop) begin
      tx_busy      <= 1'b1;
      tx_shift     <= {1'b1, down_data, 1'b0};
      tx_clk_cnt   <= BIT_LAST;
      tx_bits_left <= 4'(FB);
    end else if (tx_busy) begin
      if (tx_clk_cnt != '0) begin
        tx_clk_cnt <= tx_clk_cnt - 1'b1;
      end else begin
        tx_clk_cnt   <= BIT_LAST;
        tx_shift     <= {1'b1, tx_shift[FB-1:1]};
        tx_bits_left <= tx_bits_left - 1'b1;
        if (tx_bits_left == 4'd1) begin
          tx_busy <= 1'b0;                         // stop bit done
        end
      end
    end
  end

  // ==========================================================
  // deserializer
  // ==========================================================
  always_ff @(posedge PHY_CLKOUT) begin
    if (RESET_IN) begin
      rxd_meta <= 1'b1;
      rxd_sync <= 1'b1;
    end else begin
      rxd_meta <= uart_rxd_i;
      rxd_sync <= rxd_meta;
    end
  end

  always_ff @(posedge PHY_CLKOUT) begin
    if (RESET_IN) begin
      rx_active  <= 1'b0;
      rx_done    <= 1'b0;
      rx_clk_cnt <= '0;
      rx_bit_idx <= '0;
    end else begin
      rx_done <= 1'b0;
      if (!rx_active) begin
        if (!rxd_sync) begin
          rx_active  <= 1'b1;
          rx_clk_cnt <= HALF_LAST;                 // aim at mid start bit
          rx_bit_idx <= '0;
        end
      end else if (rx_clk_cnt != '0) begin
        rx_clk_cnt <= rx_clk_cnt - 1'b1;
      end else begin
        rx_clk_cnt <= BIT_LAST;
        rx_bit_idx <= rx_bit_idx + 1'b1;
        if (rx_bit_idx == '0 && rxd_sync) begin
          rx_active <= 1'b0;                       // glitch, not a start
        end else if (rx_bit_idx == STOP_IDX) begin
          rx_active <= 1'b0;
          rx_done   <= rxd_sync;                   // framing error drops it
        end
      end
    end
  end

  always_ff @(posedge PHY_CLKOUT) begin
    if (rx_active && rx_clk_cnt == '0 && rx_bit_idx != '0 && rx_bit_idx != STOP_IDX) begin
      rx_shift <= {rxd_sync, rx_shift[DB-1:1]};    // lsb arrives first
    end
  end

  assign up_push = rx_done & ~up_full;             // overrun loses the byte

  byte_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) up_fifo_inst (
    .PHY_CLKOUT  (PHY_CLKOUT),
    .RESET_IN    (RESET_IN),
    .push_i      (up_push),
    .push_data_i (rx_shift),
    .pop_i       (port.tx_pop),
    .pop_data_o  (port.tx_data),
    .full_o      (up_full),
    .count_o     (port.tx_count)
  );

endmodule

`default_nettype wire

// ==== uart_line_pkg.sv ====
`default_nettype none

package uart_line_pkg;

  typedef logic [7:0] byte_t;                      // one data byte

  // ==========================================================
  // fixed 8N1 frame
  // ==========================================================
  localparam int DATA_BITS  = 8;                   // lsb first
  localparam int FRAME_BITS = DATA_BITS + 2;       // start + data + stop

endpackage

`default_nettype wire

// ==== usb_bridge_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module usb_bridge_checker #(
  parameter int MAX_PKT_BYTES = 8
) (
  input  logic                 PHY_CLKOUT,
  input  logic                 RESET_IN,
  input  logic                 rx_valid_i,
  input  logic                 rx_ready_i,
  input  logic                 tx_valid_i,
  input  uart_line_pkg::byte_t tx_data_i,
  input  usb_ep_pkg::endpt_t   tx_endpt_i,
  input  logic                 tx_last_i,
  input  logic                 tx_pop_i,
  input  logic [9:0]           parallel_i,
  input  logic [2:0]           uart_txd_i
);

  localparam int N = usb_ep_pkg::NUM_UART;

  uart_line_pkg::byte_t exp_q [N][$];              // expected upstream bytes per channel
  int                   total_errors = 0;
  int                   test_errors  = 0;
  int                   tests_run    = 0;
  int                   tests_failed = 0;
  int                   pkt_bytes    = 0;          // bytes so far in the open packet
  usb_ep_pkg::endpt_t   pkt_endpt;
  logic                 stall_seen   = 1'b0;
  logic                 held         = 1'b0;       // beat waited for pop at last edge
  uart_line_pkg::byte_t held_data;
  usb_ep_pkg::endpt_t   held_endpt;
  logic                 held_last;

  // ==========================================================
  // reporting
  // ==========================================================
  task automatic mismatch(input string sig, input logic [31:0] exp_v, input logic [31:0] got_v);
    $display("Mismatch %s: expected 0x%0h, got 0x%0h at %0t ns", sig, exp_v, got_v, $time);
    test_errors++;
    total_errors++;
  endtask

  task automatic complain(input string what);
    $display("Error: %s at %0t ns", what, $time);
    test_errors++;
    total_errors++;
  endtask

  function automatic int chan_of(input usb_ep_pkg::endpt_t ep);
    for (int i = 0; i < N; i++) begin
      if (usb_ep_pkg::uart_endpt[i] == ep) return i;
    end
    return -1;                                     // not a uart endpoint
  endfunction

  function automatic int pending();
    int total;
    total = 0;
    foreach (exp_q[i]) total += exp_q[i].size();
    return total;
  endfunction

  task automatic expect_byte(input usb_ep_pkg::endpt_t ep, input uart_line_pkg::byte_t data);
    if (chan_of(ep) < 0) complain($sformatf("expected byte on endpoint 0x%0h, not a UART", ep));
    else exp_q[chan_of(ep)].push_back(data);
  endtask

  // ==========================================================
  // upstream monitor
  // ==========================================================
  task automatic take_byte();
    int                   ch;
    uart_line_pkg::byte_t want;
    ch = chan_of(tx_endpt_i);
    if (pkt_bytes == 0) begin
      pkt_endpt = tx_endpt_i;                      // tag of a fresh packet
    end else if (tx_endpt_i !== pkt_endpt) begin
      mismatch("usb_tx_endpt_o", pkt_endpt, tx_endpt_i);
    end
    pkt_bytes++;
    if (pkt_bytes > MAX_PKT_BYTES) complain($sformatf("packet longer than %0d bytes", MAX_PKT_BYTES));
    if (tx_last_i) pkt_bytes = 0;
    if (ch < 0) begin
      complain($sformatf("upstream byte 0x%0h on unknown endpoint 0x%0h", tx_data_i, tx_endpt_i));
    end else if (exp_q[ch].size() == 0) begin
      complain($sformatf("unexpected byte 0x%0h on endpoint 0x%0h", tx_data_i, tx_endpt_i));
    end else begin
      want = exp_q[ch].pop_front();
      if (tx_data_i !== want) mismatch("usb_tx_data_o", want, tx_data_i);
    end
  endtask

  always @(posedge PHY_CLKOUT) begin
    if (!RESET_IN) begin
      if (rx_valid_i && !rx_ready_i) stall_seen = 1'b1;
      if (held && !tx_valid_i) begin
        complain("usb_tx_valid_o dropped before its beat was popped");
      end else if (held) begin                    // stalled beat must hold still
        if (tx_data_i !== held_data) mismatch("usb_tx_data_o", held_data, tx_data_i);
        if (tx_endpt_i !== held_endpt) mismatch("usb_tx_endpt_o", held_endpt, tx_endpt_i);
        if (tx_last_i !== held_last) mismatch("usb_tx_last_o", held_last, tx_last_i);
      end
      if (tx_valid_i && tx_pop_i) take_byte();
    end
    held       = !RESET_IN && tx_valid_i && !tx_pop_i;
    held_data  = tx_data_i;
    held_endpt = tx_endpt_i;
    held_last  = tx_last_i;
  end

  // ==========================================================
  // per test checks
  // ==========================================================
  task automatic check_reset();
    if (tx_valid_i !== 1'b0) mismatch("usb_tx_valid_o", 0, tx_valid_i);
    if (parallel_i !== 10'h000) mismatch("usb_parallel_o", 0, parallel_i);
    if (uart_txd_i !== 3'b111) mismatch("usb_uart_txd_o", 3'b111, uart_txd_i);
  endtask

  task automatic begin_test();
    test_errors = 0;
    stall_seen  = 1'b0;
  endtask

  task automatic check_parallel(input logic [9:0] want);
    if (parallel_i !== want) mismatch("usb_parallel_o", want, parallel_i);
  endtask

  task automatic check_stall();
    if (!stall_seen) complain("usb_rx_ready_o never dropped during the fast burst");
  endtask

  task automatic check_waiting();
    if (!tx_valid_i) complain("usb_tx_valid_o was low at the end of the pop gap");
  endtask

  task automatic end_test(input logic [8*32-1:0] name);
    if (pkt_bytes != 0) complain("packet left open, usb_tx_last_o never came");
    tests_run++;
    if (test_errors == 0) begin
      $display("%0s: pass", name);
    end else begin
      tests_failed++;
      $display("%0s: fail, %0d errors", name, test_errors);
    end
  endtask

  task automatic report_summary();
    $display("tests run %0d, passed %0d, failed %0d, errors %0d",
             tests_run, tests_run - tests_failed, tests_failed, total_errors);
  endtask

endmodule

`default_nettype wire

// ==== usb_bridge_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module usb_bridge_top #(
  parameter int CLKS_PER_BIT  = 520,               // 60 MHz / 115200
  parameter int FIFO_DEPTH    = 16,
  parameter int MAX_PKT_BYTES = 8
) (
  input  logic                                PHY_CLKOUT,
  input  logic                                RESET_IN,

  input  logic                                usb_rx_valid_i,
  input  uart_line_pkg::byte_t                usb_rx_data_i,
  input  usb_ep_pkg::endpt_t                  usb_rx_endpt_i,
  input  logic                                usb_rx_last_i,
  output logic                                usb_rx_ready_o,

  output logic                                usb_tx_valid_o,
  output uart_line_pkg::byte_t                usb_tx_data_o,
  output usb_ep_pkg::endpt_t                  usb_tx_endpt_o,
  output logic                                usb_tx_last_o,
  input  logic                                usb_tx_pop_i,

  output logic [usb_ep_pkg::NUM_UART-1:0]     usb_uart_txd_o,
  input  logic [usb_ep_pkg::NUM_UART-1:0]     usb_uart_rxd_i,
  output logic [9:0]                          usb_parallel_o
);

  logic                 gpio_valid;
  uart_line_pkg::byte_t gpio_data;
  logic                 gpio_last;

  ep_port_if #(.FIFO_DEPTH(FIFO_DEPTH)) uart_port [usb_ep_pkg::NUM_UART] ();

  // ==========================================================
  // endpoint routing and upstream arbitration
  // ==========================================================
  usb_ep_arbiter #(.MAX_PKT_BYTES(MAX_PKT_BYTES)) usb_ep_arbiter_inst (
    .PHY_CLKOUT     (PHY_CLKOUT),
    .RESET_IN       (RESET_IN),
    .usb_rx_valid_i (usb_rx_valid_i),
    .usb_rx_data_i  (usb_rx_data_i),
    .usb_rx_endpt_i (usb_rx_endpt_i),
    .usb_rx_last_i  (usb_rx_last_i),
    .usb_rx_ready_o (usb_rx_ready_o),
    .usb_tx_valid_o (usb_tx_valid_o),
    .usb_tx_data_o  (usb_tx_data_o),
    .usb_tx_endpt_o (usb_tx_endpt_o),
    .usb_tx_last_o  (usb_tx_last_o),
    .usb_tx_pop_i   (usb_tx_pop_i),
    .uart           (uart_port),
    .gpio_valid_o   (gpio_valid),
    .gpio_data_o    (gpio_data),
    .gpio_last_o    (gpio_last)
  );

  gpio_endpoint gpio_endpoint_inst (
    .PHY_CLKOUT   (PHY_CLKOUT),
    .RESET_IN     (RESET_IN),
    .byte_valid_i (gpio_valid),
    .byte_data_i  (gpio_data),
    .byte_last_i  (gpio_last),
    .parallel_o   (usb_parallel_o)
  );

  // ==========================================================
  // uart channels, index 0 serves endpoint 5
  // ==========================================================
  for (genvar g = 0; g < usb_ep_pkg::NUM_UART; g++) begin : g_uart
    uart_channel #(
      .CLKS_PER_BIT (CLKS_PER_BIT),
      .FIFO_DEPTH   (FIFO_DEPTH)
    ) uart_channel_inst (
      .PHY_CLKOUT (PHY_CLKOUT),
      .RESET_IN   (RESET_IN),
      .port       (uart_port[g]),
      .uart_txd_o (usb_uart_txd_o[g]),
      .uart_rxd_i (usb_uart_rxd_i[g])
    );
  end

endmodule

`default_nettype wire

// ==== usb_bridge_vectors.txt ====
# T name | D endpoint count bytes, last on final byte | U endpoint count expected bytes
# P expected parallel | H pop gap in decimal cycles | R expect ready stall | E run test
T loopback_ep5
D 5 0a 10 21 32 43 54 65 76 87 98 a9
U 5 0a 10 21 32 43 54 65 76 87 98 a9
E
T concurrent_ep567
D 5 1 c0
D 6 1 d0
D 7 2 e0 e1
D 5 1 c1
D 6 1 d1
U 5 2 c0 c1
U 6 2 d0 d1
U 7 2 e0 e1
E
T parallel_two_byte
D 8 2 a5 3e
P 2a5
E
T parallel_one_byte
D 8 1 c7
P 300
E
T unknown_ep3
D 3 3 de ad be
P 300
E
T backpressure
H 1000
D 6 0a 01 ff 80 7f 55 aa 0f f0 3c c3
U 6 0a 01 ff 80 7f 55 aa 0f f0 3c c3
E
T downstream_stall
R
D 7 14 00 11 22 33 44 55 66 77 88 99 aa bb cc dd ee ff 5a a5 69 96
U 7 14 00 11 22 33 44 55 66 77 88 99 aa bb cc dd ee ff 5a a5 69 96
E

// ==== usb_ep_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module usb_ep_arbiter #(
  parameter int MAX_PKT_BYTES = 8
) (
  input  logic                 PHY_CLKOUT,
  input  logic                 RESET_IN,

  input  logic                 usb_rx_valid_i,
  input  uart_line_pkg::byte_t usb_rx_data_i,
  input  usb_ep_pkg::endpt_t   usb_rx_endpt_i,
  input  logic                 usb_rx_last_i,
  output logic                 usb_rx_ready_o,

  output logic                 usb_tx_valid_o,
  output uart_line_pkg::byte_t usb_tx_data_o,
  output usb_ep_pkg::endpt_t   usb_tx_endpt_o,
  output logic                 usb_tx_last_o,
  input  logic                 usb_tx_pop_i,

  ep_port_if.arb               uart [usb_ep_pkg::NUM_UART],

  output logic                 gpio_valid_o,
  output uart_line_pkg::byte_t gpio_data_o,
  output logic                 gpio_last_o
);

  localparam int N     = usb_ep_pkg::NUM_UART;
  localparam int IDX_W = $clog2(N);
  localparam usb_ep_pkg::pkt_len_t MAX_LEN = usb_ep_pkg::pkt_len_t'(MAX_PKT_BYTES);

  logic [N-1:0]          uart_hit;
  logic [N-1:0]          uart_ready;
  usb_ep_pkg::pkt_len_t  chan_count [N];
  uart_line_pkg::byte_t  chan_data [N];

  logic                  tx_active;
  logic [IDX_W-1:0]      grant_idx;
  logic [IDX_W-1:0]      rr_ptr;                   // first channel to look at
  usb_ep_pkg::pkt_len_t  remaining;

  logic                  pick_found;
  logic [IDX_W-1:0]      pick_idx;
  usb_ep_pkg::pkt_len_t  pick_len;

  // ==========================================================
  // downstream steering
  // ==========================================================
  for (genvar g = 0; g < N; g++) begin : g_port
    assign uart_hit[g]      = (usb_rx_endpt_i == usb_ep_pkg::uart_endpt[g]);
    assign uart[g].rx_valid = usb_rx_valid_i & uart_hit[g];
    assign uart[g].rx_data  = usb_rx_data_i;
    assign uart_ready[g]    = uart[g].rx_ready;
    assign chan_count[g]    = usb_ep_pkg::pkt_len_t'(uart[g].tx_count);
    assign chan_data[g]     = uart[g].tx_data;
    assign uart[g].tx_pop   = usb_tx_pop_i & tx_active & (grant_idx == IDX_W'(g));
  end

  // gpio and unknown endpoints always take the byte
  assign usb_rx_ready_o = ~|(uart_hit & ~uart_ready);

  assign gpio_valid_o = usb_rx_valid_i & (usb_rx_endpt_i == usb_ep_pkg::EP_PARALLEL);
  assign gpio_data_o  = usb_rx_data_i;
  assign gpio_last_o  = usb_rx_last_i;

  // ==========================================================
  // upstream round robin
  // ==========================================================
  always_comb begin
    int cand;
    pick_found = 1'b0;
    pick_idx   = '0;
    for (int k = 0; k < N; k++) begin
      cand = (int'(rr_ptr) + k) % N;
      if (!pick_found && chan_count[cand] != '0) begin
        pick_found = 1'b1;
        pick_idx   = IDX_W'(cand);
      end
    end
    pick_len = (chan_count[pick_idx] > MAX_LEN) ? MAX_LEN : chan_count[pick_idx];
  end

  always_ff @(posedge PHY_CLKOUT) begin
    if (RESET_IN) begin
      tx_active <= 1'b0;
      grant_idx <= '0;
      rr_ptr    <= '0;
      remaining <= '0;
    end else if (!tx_active) begin
      if (pick_found) begin
        tx_active <= 1'b1;
        grant_idx <= pick_idx;
        remaining <= pick_len;                     // length frozen at grant
        rr_ptr    <= (pick_idx == IDX_W'(N - 1)) ? '0 : pick_idx + 1'b1;
      end
    end else if (usb_tx_pop_i) begin
      remaining <= remaining - 1'b1;
      if (remaining == 12'd1) begin
        tx_active <= 1'b0;                         // packet closed
      end
    end
  end

  assign usb_tx_valid_o = tx_active;
  assign usb_tx_data_o  = chan_data[grant_idx];
  assign usb_tx_endpt_o = usb_ep_pkg::uart_endpt[grant_idx];
  assign usb_tx_last_o  = tx_active & (remaining == 12'd1);

  // beat held by the channel fifo head must not move while stalled
  a_tx_stable: assert property (@(posedge PHY_CLKOUT) disable iff (RESET_IN)
    usb_tx_valid_o && !usb_tx_pop_i |=> usb_tx_valid_o && $stable(usb_tx_data_o)
      && $stable(usb_tx_endpt_o) && $stable(usb_tx_last_o));

endmodule

`default_nettype wire

// ==== usb_ep_pkg.sv ====
`default_nettype none

package usb_ep_pkg;

  // ==========================================================
  // endpoint numbering
  // ==========================================================
  typedef logic [3:0] endpt_t;                     // usb endpoint number

  localparam endpt_t EP_UART1    = 4'h5;
  localparam endpt_t EP_UART2    = 4'h6;
  localparam endpt_t EP_UART3    = 4'h7;
  localparam endpt_t EP_PARALLEL = 4'h8;

  localparam int NUM_UART = 3;

  // channel index to endpoint
  localparam endpt_t uart_endpt [NUM_UART] = '{EP_UART1, EP_UART2, EP_UART3};

  // ==========================================================
  // packet sizing
  // ==========================================================
  typedef logic [11:0] pkt_len_t;                  // same width as tx length upstream

endpackage

`default_nettype wire
